// ==== hw/id_pkg.sv ====
////////////////////
// Decode stage package
// Widths, opcodes, control encodings and the bundles
// passed between the decode blocks
////////////////////

package id_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  // RV32I major opcodes
  localparam logic [6:0] OPCODE_LOAD   = 7'h03;
  localparam logic [6:0] OPCODE_STORE  = 7'h23;
  localparam logic [6:0] OPCODE_OP     = 7'h33;
  localparam logic [6:0] OPCODE_OP_IMM = 7'h13;
  localparam logic [6:0] OPCODE_LUI    = 7'h37;
  localparam logic [6:0] OPCODE_AUIPC  = 7'h17;
  localparam logic [6:0] OPCODE_BRANCH = 7'h63;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U} imm_sel_e;

  typedef enum logic {WB_EX, WB_LSU} wb_sel_e;

  // Same encoding as the data bus type field
  typedef enum logic [1:0] {LSU_WORD = 2'b00, LSU_HALF = 2'b01, LSU_BYTE = 2'b10} lsu_type_e;

  typedef struct packed {
    logic            valid;
    logic            new_instr;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
  } instr_in_t;

  typedef struct packed {
    alu_op_e         alu_op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic            lsu_req;
    logic            lsu_we;
    lsu_type_e       lsu_type;
    logic            lsu_sign_ext;
    logic [XLEN-1:0] lsu_wdata;
  } issue_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_we;
    wb_sel_e               wb_sel;
    op_a_sel_e             op_a_sel;
    logic                  op_b_is_imm;
    imm_sel_e              imm_sel;
    alu_op_e               alu_op;
    logic                  lsu_req;
    logic                  lsu_we;
    lsu_type_e             lsu_type;
    logic                  lsu_sign_ext;
    logic                  is_branch;
    logic                  illegal;
  } dec_ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] i;
    logic [XLEN-1:0] s;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] u;
  } imm_set_t;

endpackage

// ==== hw/id_decoder.sv ====
////////////////////
// RV32I instruction decoder
// Control fields and sign-extended immediates per opcode
////////////////////

`timescale 1ns/1ps

module id_decoder (
  input  logic [id_pkg::XLEN-1:0] instr_word_i,
  output id_pkg::dec_ctrl_t       ctrl_o,
  output id_pkg::imm_set_t        imm_o
);

  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_word_i[6:0];
  assign funct3 = instr_word_i[14:12];
  assign funct7 = instr_word_i[31:25];

  ////////////////////
  // Immediates
  ////////////////////

  assign imm_o.i = {{20{instr_word_i[31]}}, instr_word_i[31:20]};
  assign imm_o.s = {{20{instr_word_i[31]}}, instr_word_i[31:25], instr_word_i[11:7]};
  assign imm_o.b = {{19{instr_word_i[31]}}, instr_word_i[31], instr_word_i[7],
                    instr_word_i[30:25], instr_word_i[11:8], 1'b0};
  assign imm_o.u = {instr_word_i[31:12], 12'b0};

  ////////////////////
  // Control decode
  ////////////////////

  always_comb begin
    ctrl_o              = '0;
    ctrl_o.rs1          = instr_word_i[19:15];
    ctrl_o.rs2          = instr_word_i[24:20];
    ctrl_o.rd           = instr_word_i[11:7];
    ctrl_o.wb_sel       = WB_EX;
    ctrl_o.op_a_sel     = OP_A_REG_A;
    ctrl_o.imm_sel      = IMM_I;
    ctrl_o.alu_op       = ALU_ADD;
    ctrl_o.lsu_type     = LSU_WORD;

    unique case (opcode)
      OPCODE_LUI, OPCODE_AUIPC: begin
        ctrl_o.reg_we      = 1'b1;
        ctrl_o.op_a_sel    = (opcode == OPCODE_LUI) ? OP_A_ZERO : OP_A_CURRPC;
        ctrl_o.op_b_is_imm = 1'b1;
        ctrl_o.imm_sel     = IMM_U;
      end
      OPCODE_OP_IMM: begin
        ctrl_o.reg_we      = 1'b1;
        ctrl_o.op_b_is_imm = 1'b1;
        unique case (funct3)
          3'b000: ctrl_o.alu_op = ALU_ADD;
          3'b010: ctrl_o.alu_op = ALU_SLT;
          3'b011: ctrl_o.alu_op = ALU_SLTU;
          3'b100: ctrl_o.alu_op = ALU_XOR;
          3'b110: ctrl_o.alu_op = ALU_OR;
          3'b111: ctrl_o.alu_op = ALU_AND;
          3'b001: begin
            ctrl_o.alu_op  = ALU_SLL;
            ctrl_o.illegal = (funct7 != 7'b0000000);
          end
          default: begin
            // Shift right with bit 30 selecting arithmetic
            ctrl_o.alu_op  = funct7[5] ? ALU_SRA : ALU_SRL;
            ctrl_o.illegal = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end
      OPCODE_OP: begin
        ctrl_o.reg_we = 1'b1;
        unique case ({funct7, funct3})
          {7'b0000000, 3'b000}: ctrl_o.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: ctrl_o.alu_op = ALU_SUB;
          {7'b0000000, 3'b001}: ctrl_o.alu_op = ALU_SLL;
          {7'b0000000, 3'b010}: ctrl_o.alu_op = ALU_SLT;
          {7'b0000000, 3'b011}: ctrl_o.alu_op = ALU_SLTU;
          {7'b0000000, 3'b100}: ctrl_o.alu_op = ALU_XOR;
          {7'b0000000, 3'b101}: ctrl_o.alu_op = ALU_SRL;
          {7'b0100000, 3'b101}: ctrl_o.alu_op = ALU_SRA;
          {7'b0000000, 3'b110}: ctrl_o.alu_op = ALU_OR;
          {7'b0000000, 3'b111}: ctrl_o.alu_op = ALU_AND;
          default:              ctrl_o.illegal = 1'b1;
        endcase
      end
      OPCODE_LOAD, OPCODE_STORE: begin
        // Address is rs1 plus offset
        ctrl_o.lsu_req      = 1'b1;
        ctrl_o.lsu_we       = (opcode == OPCODE_STORE);
        ctrl_o.reg_we       = (opcode == OPCODE_LOAD);
        ctrl_o.wb_sel       = WB_LSU;
        ctrl_o.op_b_is_imm  = 1'b1;
        ctrl_o.imm_sel      = (opcode == OPCODE_STORE) ? IMM_S : IMM_I;
        ctrl_o.lsu_sign_ext = ~funct3[2];
        unique case (funct3[1:0])
          2'b00:   ctrl_o.lsu_type = LSU_BYTE;
          2'b01:   ctrl_o.lsu_type = LSU_HALF;
          2'b10:   ctrl_o.lsu_type = LSU_WORD;
          default: ctrl_o.illegal  = 1'b1;
        endcase
        // No unsigned word load and no unsigned store forms
        if (funct3[2] && (opcode == OPCODE_STORE || funct3[1])) begin
          ctrl_o.illegal = 1'b1;
        end
      end
      OPCODE_BRANCH: begin
        ctrl_o.is_branch   = 1'b1;
        ctrl_o.op_a_sel    = OP_A_CURRPC;
        ctrl_o.op_b_is_imm = 1'b1;
        ctrl_o.imm_sel     = IMM_B;
        unique case (funct3)
          3'b000:  ctrl_o.alu_op  = ALU_EQ;
          3'b001:  ctrl_o.alu_op  = ALU_NE;
          3'b100:  ctrl_o.alu_op  = ALU_LT;
          3'b101:  ctrl_o.alu_op  = ALU_GE;
          3'b110:  ctrl_o.alu_op  = ALU_LTU;
          3'b111:  ctrl_o.alu_op  = ALU_GEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal encodings carry no side effects
    if (ctrl_o.illegal) begin
      ctrl_o.reg_we    = 1'b0;
      ctrl_o.lsu_req   = 1'b0;
      ctrl_o.lsu_we    = 1'b0;
      ctrl_o.is_branch = 1'b0;
    end
  end

endmodule

// ==== hw/id_regfile.sv ====
////////////////////
// Register file
// Two read ports, one write port, x0 reads zero
////////////////////

`timescale 1ns/1ps

module id_regfile (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [id_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] raddr_b_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [id_pkg::XLEN-1:0]       wdata_i,
  input  logic                          we_i,
  output logic [id_pkg::XLEN-1:0]       rdata_a_o,
  output logic [id_pkg::XLEN-1:0]       rdata_b_o
);

  import id_pkg::*;

  // Only x1 to x31 are stored
  logic [XLEN-1:0] regs_q [NUM_REGS-1:1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational read
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== hw/id_operand_mux.sv ====
////////////////////
// Operand and write-back muxes
// Builds the issue bundle and picks the register write data
////////////////////

`timescale 1ns/1ps

module id_operand_mux (
  input  id_pkg::dec_ctrl_t       ctrl_i,
  input  id_pkg::imm_set_t        imm_i,
  input  logic [id_pkg::XLEN-1:0] pc_i,
  input  logic [id_pkg::XLEN-1:0] rdata_a_i,
  input  logic [id_pkg::XLEN-1:0] rdata_b_i,
  input  logic [id_pkg::XLEN-1:0] ex_result_i,
  input  logic [id_pkg::XLEN-1:0] lsu_result_i,
  input  logic                    executing_i,
  output id_pkg::issue_t          issue_o,
  output logic [id_pkg::XLEN-1:0] wdata_o
);

  import id_pkg::*;

  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] imm_b;

  // Operand A
  always_comb begin
    unique case (ctrl_i.op_a_sel)
      OP_A_REG_A:  operand_a = rdata_a_i;
      OP_A_CURRPC: operand_a = pc_i;
      default:     operand_a = '0;
    endcase
  end

  // Immediate for operand B
  always_comb begin
    unique case (ctrl_i.imm_sel)
      IMM_S:   imm_b = imm_i.s;
      IMM_B:   imm_b = imm_i.b;
      IMM_U:   imm_b = imm_i.u;
      default: imm_b = imm_i.i;
    endcase
  end

  assign issue_o.alu_op       = ctrl_i.alu_op;
  assign issue_o.operand_a    = operand_a;
  assign issue_o.operand_b    = ctrl_i.op_b_is_imm ? imm_b : rdata_b_i;
  // Request only while the instruction is still in flight
  assign issue_o.lsu_req      = ctrl_i.lsu_req & executing_i;
  assign issue_o.lsu_we       = ctrl_i.lsu_we;
  assign issue_o.lsu_type     = ctrl_i.lsu_type;
  assign issue_o.lsu_sign_ext = ctrl_i.lsu_sign_ext;
  assign issue_o.lsu_wdata    = rdata_b_i;

  assign wdata_o = (ctrl_i.wb_sel == WB_LSU) ? lsu_result_i : ex_result_i;

endmodule

// ==== hw/id_wb_fsm.sv ====
////////////////////
// Write-back FSM
// Stalls multi-cycle instructions, drives write enable and retire
////////////////////

`timescale 1ns/1ps

module id_wb_fsm (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              instr_new_i,
  input  logic              instr_valid_i,
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  logic              branch_taken_i,
  input  logic              ex_valid_i,
  input  logic              lsu_valid_i,
  output logic              executing_o,
  output logic              reg_we_o,
  output logic              id_ready_o,
  output logic              instr_ret_o,
  output logic              illegal_o
);

  typedef enum logic {ST_IDLE, ST_WAIT} state_e;

  state_e state_q, state_d;
  logic   done_q, done_d;
  logic   multicycle;
  logic   issue_new;

  assign illegal_o  = instr_valid_i & ctrl_i.illegal;
  assign multicycle = ctrl_i.lsu_req | ctrl_i.is_branch;
  assign issue_new  = instr_valid_i & instr_new_i & ~ctrl_i.illegal;

  // In flight while new or while multi-cycle and not yet completed
  assign executing_o = instr_valid_i & ~ctrl_i.illegal &
                       (instr_new_i | (multicycle & ~done_q));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  always_comb begin
    state_d     = state_q;
    done_d      = done_q;
    reg_we_o    = 1'b0;
    id_ready_o  = 1'b1;
    instr_ret_o = 1'b0;

    unique case (state_q)
      ST_IDLE: begin
        if (issue_new) begin
          if (ctrl_i.lsu_req || (ctrl_i.is_branch && branch_taken_i)) begin
            state_d    = ST_WAIT;
            done_d     = 1'b0;
            id_ready_o = 1'b0;
          end else begin
            // Single cycle, or branch not taken
            done_d      = 1'b1;
            reg_we_o    = ctrl_i.reg_we;
            instr_ret_o = 1'b1;
          end
        end
      end
      default: begin
        if ((ctrl_i.lsu_req && lsu_valid_i) || (!ctrl_i.lsu_req && ex_valid_i)) begin
          state_d     = ST_IDLE;
          done_d      = 1'b1;
          reg_we_o    = ctrl_i.reg_we;
          instr_ret_o = 1'b1;
        end else begin
          id_ready_o = 1'b0;
        end
      end
    endcase
  end

endmodule

// ==== hw/id_stage.sv ====
////////////////////
// RV32I decode stage
// Decoder, register file, operand muxes and write-back FSM
////////////////////

`timescale 1ns/1ps

module id_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  id_pkg::instr_in_t       instr_i,
  input  logic                    branch_taken_i,
  input  logic                    ex_valid_i,
  input  logic                    lsu_valid_i,
  input  logic [id_pkg::XLEN-1:0] ex_result_i,
  input  logic [id_pkg::XLEN-1:0] lsu_result_i,
  output id_pkg::issue_t          issue_o,
  output logic                    id_ready_o,
  output logic                    instr_ret_o,
  output logic                    illegal_insn_o
);

  import id_pkg::*;

  dec_ctrl_t       dec_ctrl;
  imm_set_t        imm_set;
  logic [XLEN-1:0] rdata_a;
  logic [XLEN-1:0] rdata_b;
  logic [XLEN-1:0] rf_wdata;
  logic            rf_we;
  logic            executing;

  id_decoder id_decoder_inst (
    .instr_word_i (instr_i.instr),
    .ctrl_o       (dec_ctrl),
    .imm_o        (imm_set)
  );

  id_regfile id_regfile_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (dec_ctrl.rs1),
    .raddr_b_i (dec_ctrl.rs2),
    .waddr_i   (dec_ctrl.rd),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  id_operand_mux id_operand_mux_inst (
    .ctrl_i       (dec_ctrl),
    .imm_i        (imm_set),
    .pc_i         (instr_i.pc),
    .rdata_a_i    (rdata_a),
    .rdata_b_i    (rdata_b),
    .ex_result_i  (ex_result_i),
    .lsu_result_i (lsu_result_i),
    .executing_i  (executing),
    .issue_o      (issue_o),
    .wdata_o      (rf_wdata)
  );

  id_wb_fsm id_wb_fsm_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_new_i    (instr_i.new_instr),
    .instr_valid_i  (instr_i.valid),
    .ctrl_i         (dec_ctrl),
    .branch_taken_i (branch_taken_i),
    .ex_valid_i     (ex_valid_i),
    .lsu_valid_i    (lsu_valid_i),
    .executing_o    (executing),
    .reg_we_o       (rf_we),
    .id_ready_o     (id_ready_o),
    .instr_ret_o    (instr_ret_o),
    .illegal_o      (illegal_insn_o)
  );

endmodule

// ==== tb/tb_id_stage.sv ====
////////////////////
// Decode stage testbench
// Directed tests, acting as the fetch and execute stages
////////////////////

`timescale 1ns/1ps

module tb_id_stage;

  import id_pkg::*;

  // Well above the roughly 55 cycles the tests take
  localparam int MAX_CYCLES = 400;

  logic            clk_i;
  logic            rst_ni;
  instr_in_t       instr_i;
  logic            branch_taken_i;
  logic            ex_valid_i;
  logic            lsu_valid_i;
  logic [XLEN-1:0] ex_result_i;
  logic [XLEN-1:0] lsu_result_i;
  issue_t          issue_o;
  logic            id_ready_o;
  logic            instr_ret_o;
  logic            illegal_insn_o;

  // Expected register contents
  logic [XLEN-1:0] exp_regs [NUM_REGS];
  logic [31:0]     lfsr_q;
  int              cycles = 0;
  int              checks = 0;
  int              errors = 0;

  id_stage id_stage_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_i        (instr_i),
    .branch_taken_i (branch_taken_i),
    .ex_valid_i     (ex_valid_i),
    .lsu_valid_i    (lsu_valid_i),
    .ex_result_i    (ex_result_i),
    .lsu_result_i   (lsu_result_i),
    .issue_o        (issue_o),
    .id_ready_o     (id_ready_o),
    .instr_ret_o    (instr_ret_o),
    .illegal_insn_o (illegal_insn_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Galois LFSR with taps 32 30 26 25
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w      = {w[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPCODE_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE};
  endfunction

  // Offset bit 0 is implied zero
  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
  endfunction

  function automatic issue_t make_issue(input alu_op_e op, input logic [31:0] a,
                                        input logic [31:0] b, input logic req,
                                        input logic we, input lsu_type_e typ,
                                        input logic sext);
    issue_t r;
    r              = '0;
    r.alu_op       = op;
    r.operand_a    = a;
    r.operand_b    = b;
    r.lsu_req      = req;
    r.lsu_we       = we;
    r.lsu_type     = typ;
    r.lsu_sign_ext = sext;
    return r;
  endfunction

  task automatic check_issue(input issue_t got, input issue_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAILED at %0t ns: issue_o got %h expected %h", $time, got, want);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, want);
    end
  endtask

  task automatic tick();
    @(posedge clk_i);
    #2;
  endtask

  task automatic send(input logic [31:0] word, input logic [31:0] pc);
    tick();
    instr_i.valid     = 1'b1;
    instr_i.new_instr = 1'b1;
    instr_i.instr     = word;
    instr_i.pc        = pc;
  endtask

  task automatic test_done(input string name, input int err0);
    $display("test %-14s finished with %0d errors", name, errors - err0);
  endtask

  // Instruction that retires in its new cycle
  task automatic single(input logic [31:0] word, input logic [31:0] pc, input issue_t want,
                        input logic [31:0] result, input logic wr);
    issue_t exp_q;
    exp_q           = want;
    // Store data port always carries rs2
    exp_q.lsu_wdata = exp_regs[word[24:20]];
    send(word, pc);
    ex_result_i = result;
    #1;
    check_issue(issue_o, exp_q);
    check_bit("instr_ret_o", instr_ret_o, 1'b1);
    check_bit("id_ready_o", id_ready_o, 1'b1);
    if (wr && word[11:7] != 5'd0) begin
      exp_regs[word[11:7]] = result;
    end
  endtask

  // Load, store or taken branch that completes after delay wait cycles
  task automatic multi(input logic [31:0] word, input logic [31:0] pc, input issue_t want,
                       input int delay, input logic via_lsu, input logic [31:0] result,
                       input logic wr);
    issue_t exp_q;
    exp_q           = want;
    exp_q.lsu_wdata = exp_regs[word[24:20]];
    send(word, pc);
    branch_taken_i = ~via_lsu;
    #1;
    check_issue(issue_o, exp_q);
    check_bit("id_ready_o", id_ready_o, 1'b0);
    check_bit("instr_ret_o", instr_ret_o, 1'b0);
    for (int i = 0; i < delay; i++) begin
      tick();
      instr_i.new_instr = 1'b0;
      branch_taken_i    = 1'b0;
      #1;
      check_issue(issue_o, exp_q);
      check_bit("id_ready_o", id_ready_o, 1'b0);
      check_bit("instr_ret_o", instr_ret_o, 1'b0);
    end
    tick();
    instr_i.new_instr = 1'b0;
    branch_taken_i    = 1'b0;
    lsu_valid_i       = via_lsu;
    ex_valid_i        = ~via_lsu;
    // Other result bus carries the inverse so a wrong pick shows
    lsu_result_i      = via_lsu ? result : ~result;
    ex_result_i       = via_lsu ? ~result : result;
    #1;
    check_issue(issue_o, exp_q);
    check_bit("instr_ret_o", instr_ret_o, 1'b1);
    check_bit("id_ready_o", id_ready_o, 1'b1);
    if (wr && word[11:7] != 5'd0) begin
      exp_regs[word[11:7]] = result;
    end
    tick();
    lsu_valid_i   = 1'b0;
    ex_valid_i    = 1'b0;
    instr_i.valid = 1'b0;
  endtask

  // ADD x0 reads two registers onto the operands
  task automatic probe(input logic [4:0] ra, input logic [4:0] rb);
    single(enc_r(7'h00, rb, ra, 3'b000, 5'd0), 32'h0000_0100,
           make_issue(ALU_ADD, exp_regs[ra], exp_regs[rb], 1'b0, 1'b0, LSU_WORD, 1'b0),
           32'h0, 1'b1);
  endtask

  task automatic r_op(input logic [6:0] f7, input logic [2:0] f3, input alu_op_e op,
                      input logic [31:0] result);
    single(enc_r(f7, 5'd9, 5'd8, f3, 5'd10), 32'h0000_0180,
           make_issue(op, exp_regs[8], exp_regs[9], 1'b0, 1'b0, LSU_WORD, 1'b0),
           result, 1'b1);
  endtask

  task automatic check_illegal(input logic [31:0] word);
    logic [31:0] v;
    rand_word(v);
    send(word, 32'h0000_0400);
    ex_result_i = v;
    #1;
    check_bit("illegal_insn_o", illegal_insn_o, 1'b1);
    check_bit("issue_o.lsu_req", issue_o.lsu_req, 1'b0);
    check_bit("instr_ret_o", instr_ret_o, 1'b0);
    tick();
    instr_i.valid = 1'b0;
    #1;
    check_bit("illegal_insn_o", illegal_insn_o, 1'b0);
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_addi_lui();
    logic [31:0] v;
    int          err0;
    err0 = errors;
    rand_word(v);
    single(enc_i(12'h123, 5'd0, 3'b000, 5'd5, OPCODE_OP_IMM), 32'h0000_0100,
           make_issue(ALU_ADD, 32'h0, 32'h0000_0123, 1'b0, 1'b0, LSU_WORD, 1'b0), v, 1'b1);
    single(enc_i(12'hF80, 5'd5, 3'b000, 5'd6, OPCODE_OP_IMM), 32'h0000_0104,
           make_issue(ALU_ADD, v, 32'hFFFF_FF80, 1'b0, 1'b0, LSU_WORD, 1'b0),
           v + 32'hFFFF_FF80, 1'b1);
    single({20'hABCDE, 5'd7, OPCODE_LUI}, 32'h0000_0108,
           make_issue(ALU_ADD, 32'h0, 32'hABCD_E000, 1'b0, 1'b0, LSU_WORD, 1'b0),
           32'hABCD_E000, 1'b1);
    rand_word(v);
    single(enc_i(12'h001, 5'd0, 3'b000, 5'd0, OPCODE_OP_IMM), 32'h0000_010C,
           make_issue(ALU_ADD, 32'h0, 32'h1, 1'b0, 1'b0, LSU_WORD, 1'b0), v, 1'b1);
    probe(5'd0, 5'd6);
    probe(5'd5, 5'd7);
    test_done("ADDI and LUI", err0);
  endtask

  task automatic test_rtype();
    logic [31:0] a;
    logic [31:0] b;
    int          err0;
    err0 = errors;
    rand_word(a);
    rand_word(b);
    single(enc_i(12'h000, 5'd0, 3'b000, 5'd8, OPCODE_OP_IMM), 32'h0000_0140,
           make_issue(ALU_ADD, 32'h0, 32'h0, 1'b0, 1'b0, LSU_WORD, 1'b0), a, 1'b1);
    single(enc_i(12'h000, 5'd0, 3'b000, 5'd9, OPCODE_OP_IMM), 32'h0000_0144,
           make_issue(ALU_ADD, 32'h0, 32'h0, 1'b0, 1'b0, LSU_WORD, 1'b0), b, 1'b1);
    r_op(7'h00, 3'b000, ALU_ADD, a + b);
    r_op(7'h20, 3'b000, ALU_SUB, a - b);
    r_op(7'h00, 3'b010, ALU_SLT, {31'b0, $signed(a) < $signed(b)});
    r_op(7'h20, 3'b101, ALU_SRA, $signed(a) >>> b[4:0]);
    r_op(7'h00, 3'b100, ALU_XOR, a ^ b);
    probe(5'd10, 5'd8);
    test_done("R-type", err0);
  endtask

  task automatic test_load();
    logic [31:0] v;
    int          err0;
    err0 = errors;
    rand_word(v);
    multi(enc_i(12'h010, 5'd8, 3'b010, 5'd11, OPCODE_LOAD), 32'h0000_0200,
          make_issue(ALU_ADD, exp_regs[8], 32'h10, 1'b1, 1'b0, LSU_WORD, 1'b1),
          3, 1'b1, v, 1'b1);
    rand_word(v);
    // Unsigned byte load without a wait cycle
    multi(enc_i(12'h7FF, 5'd9, 3'b100, 5'd12, OPCODE_LOAD), 32'h0000_0204,
          make_issue(ALU_ADD, exp_regs[9], 32'h7FF, 1'b1, 1'b0, LSU_BYTE, 1'b0),
          0, 1'b1, v, 1'b1);
    probe(5'd11, 5'd12);
    test_done("load", err0);
  endtask

  task automatic test_store();
    logic [31:0] v;
    int          err0;
    err0 = errors;
    rand_word(v);
    multi(enc_s(12'hFFC, 5'd9, 5'd8, 3'b010), 32'h0000_0240,
          make_issue(ALU_ADD, exp_regs[8], 32'hFFFF_FFFC, 1'b1, 1'b1, LSU_WORD, 1'b1),
          0, 1'b1, v, 1'b0);
    multi(enc_s(12'h020, 5'd9, 5'd8, 3'b001), 32'h0000_0244,
          make_issue(ALU_ADD, exp_regs[8], 32'h20, 1'b1, 1'b1, LSU_HALF, 1'b1),
          1, 1'b1, ~v, 1'b0);
    multi(enc_s(12'h7E1, 5'd9, 5'd8, 3'b000), 32'h0000_0248,
          make_issue(ALU_ADD, exp_regs[8], 32'h7E1, 1'b1, 1'b1, LSU_BYTE, 1'b1),
          2, 1'b1, v, 1'b0);
    // x28 and x1 sit in the rd field of the stores
    probe(5'd28, 5'd1);
    test_done("store", err0);
  endtask

  task automatic test_branch();
    logic [31:0] v;
    int          err0;
    err0 = errors;
    rand_word(v);
    single(enc_b(13'h1FF0, 5'd9, 5'd8, 3'b000), 32'h0000_0300,
           make_issue(ALU_EQ, 32'h0000_0300, 32'hFFFF_FFF0, 1'b0, 1'b0, LSU_WORD, 1'b0),
           v, 1'b0);
    multi(enc_b(13'h0842, 5'd9, 5'd8, 3'b100), 32'h0000_0304,
          make_issue(ALU_LT, 32'h0000_0304, 32'h0000_0842, 1'b0, 1'b0, LSU_WORD, 1'b0),
          2, 1'b0, v, 1'b0);
    // Registers named by the rd field bits of both branches
    probe(5'd17, 5'd3);
    test_done("branch", err0);
  endtask

  task automatic test_illegal();
    int err0;
    err0 = errors;
    check_illegal({7'h00, 5'd9, 5'd8, 3'b000, 5'd13, 7'h7F});
    // Unsigned word load does not exist in RV32I
    check_illegal(enc_i(12'h004, 5'd8, 3'b110, 5'd13, OPCODE_LOAD));
    probe(5'd13, 5'd8);
    test_done("illegal", err0);
  endtask

  initial begin
    lfsr_q         = 32'd48;
    rst_ni         = 1'b0;
    instr_i        = '0;
    branch_taken_i = 1'b0;
    ex_valid_i     = 1'b0;
    lsu_valid_i    = 1'b0;
    ex_result_i    = '0;
    lsu_result_i   = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      exp_regs[i] = '0;
    end
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    #1;
    check_bit("id_ready_o", id_ready_o, 1'b1);
    check_bit("instr_ret_o", instr_ret_o, 1'b0);
    check_bit("issue_o.lsu_req", issue_o.lsu_req, 1'b0);

    test_addi_lui();
    test_rtype();
    test_load();
    test_store();
    test_branch();
    test_illegal();

    $display("%0d checks run, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
hw/id_pkg.sv
hw/id_decoder.sv
hw/id_regfile.sv
hw/id_operand_mux.sv
hw/id_wb_fsm.sv
hw/id_stage.sv
tb/tb_id_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_id_stage
FILELIST  := vlog.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
